/* rv_isa_pkg.sv */
// RV32I instruction encodings
package rv_isa_pkg;

  // architectural widths
  localparam int xlen      = 32;
  localparam int reg_idx_w = 5;
  localparam int num_regs  = 1 << reg_idx_w;
  localparam int shamt_w   = 5;
  localparam int opcode_w  = 7;

  // major opcodes, bits [6:0]
  typedef enum logic [opcode_w-1:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_op     = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  // funct3 for op and op_imm
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // funct3 for loads, stores and jalr
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;
  localparam logic [2:0] f3_jalr   = 3'b000;

  // funct7 for the base and alternate forms
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  // fixed whole-word encodings
  localparam logic [xlen-1:0] nop_inst    = 32'h0000_0013;
  localparam logic [xlen-1:0] ebreak_inst = 32'h0010_0073;

endpackage

/* rv_core_pkg.sv */
// core microarchitecture types
package rv_core_pkg;

  localparam logic [rv_isa_pkg::xlen-1:0] reset_pc = '0;

  // data memory geometry
  localparam int dmem_words = 256;
  localparam int dmem_idx_w = $clog2(dmem_words);

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_beq,
    alu_bne,
    alu_blt,
    alu_bge,
    alu_bltu,
    alu_bgeu,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    mw_byte = 2'd0,
    mw_half = 2'd1,
    mw_word = 2'd2
  } mem_width_e;

  // execute stage control, one per decoded instruction
  typedef struct packed {
    alu_op_e    alu_op;
    mem_width_e mem_width;
    logic       reg_wen;
    logic       mem_wen;
    logic       is_load;
    logic       is_unsigned;
    logic       need_imm;
    logic       pc_operand;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       is_ebreak;
    logic       illegal;
  } ctrl_t;

  typedef struct packed {
    logic                        valid;
    logic [rv_isa_pkg::xlen-1:0] addr;
    logic [rv_isa_pkg::xlen-1:0] data;
    mem_width_e                  width;
  } store_t;

endpackage

/* rv_decoder.sv */
// RV32I instruction decoder
`timescale 1ns/10ps

module rv_decoder (
  input  logic [rv_isa_pkg::xlen-1:0]      inst,
  output logic [rv_isa_pkg::reg_idx_w-1:0] rd,
  output logic [rv_isa_pkg::reg_idx_w-1:0] rs1,
  output logic [rv_isa_pkg::reg_idx_w-1:0] rs2,
  output logic [rv_isa_pkg::xlen-1:0]      imm,
  output rv_core_pkg::ctrl_t               ctrl
);

  rv_isa_pkg::opcode_e            opcode;
  logic [2:0]                     funct3;
  logic [6:0]                     funct7;
  logic                           is_shift;
  logic [rv_isa_pkg::xlen-1:0]    imm_i;
  logic [rv_isa_pkg::xlen-1:0]    imm_s;
  logic [rv_isa_pkg::xlen-1:0]    imm_b;
  logic [rv_isa_pkg::xlen-1:0]    imm_u;
  logic [rv_isa_pkg::xlen-1:0]    imm_j;

  // shared by op and op_imm
  function automatic rv_core_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    rv_core_pkg::alu_op_e op;
    case (f3)
      rv_isa_pkg::f3_add_sub: op = alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
      rv_isa_pkg::f3_sll:     op = rv_core_pkg::alu_sll;
      rv_isa_pkg::f3_slt:     op = rv_core_pkg::alu_slt;
      rv_isa_pkg::f3_sltu:    op = rv_core_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:     op = rv_core_pkg::alu_xor;
      rv_isa_pkg::f3_srl_sra: op = alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
      rv_isa_pkg::f3_or:      op = rv_core_pkg::alu_or;
      default:                op = rv_core_pkg::alu_and;
    endcase
    return op;
  endfunction

  assign opcode   = rv_isa_pkg::opcode_e'(inst[6:0]);
  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];
  assign rd       = inst[11:7];
  assign rs1      = inst[19:15];
  assign rs2      = inst[24:20];
  assign is_shift = (funct3 == rv_isa_pkg::f3_sll) || (funct3 == rv_isa_pkg::f3_srl_sra);

  // sign-extended immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl           = '0;
    ctrl.alu_op    = rv_core_pkg::alu_add;
    ctrl.mem_width = rv_core_pkg::mw_word;
    imm            = '0;
    case (opcode)
      rv_isa_pkg::op_lui: begin
        ctrl.alu_op   = rv_core_pkg::alu_pass_b;
        ctrl.need_imm = 1'b1;
        ctrl.reg_wen  = 1'b1;
        imm           = imm_u;
      end
      rv_isa_pkg::op_auipc: begin
        ctrl.pc_operand = 1'b1;
        ctrl.need_imm   = 1'b1;
        ctrl.reg_wen    = 1'b1;
        imm             = imm_u;
      end
      rv_isa_pkg::op_jal: begin
        ctrl.pc_operand = 1'b1;
        ctrl.need_imm   = 1'b1;
        ctrl.reg_wen    = 1'b1;
        ctrl.is_jal     = 1'b1;
        imm             = imm_j;
      end
      rv_isa_pkg::op_jalr: begin
        ctrl.need_imm = 1'b1;
        ctrl.reg_wen  = 1'b1;
        ctrl.is_jalr  = 1'b1;
        ctrl.illegal  = (funct3 != rv_isa_pkg::f3_jalr);
        imm           = imm_i;
      end
      rv_isa_pkg::op_branch: begin
        // compares rs1 with rs2, target adder lives in the core
        ctrl.is_branch = 1'b1;
        imm            = imm_b;
        case (funct3)
          rv_isa_pkg::f3_beq:  ctrl.alu_op = rv_core_pkg::alu_beq;
          rv_isa_pkg::f3_bne:  ctrl.alu_op = rv_core_pkg::alu_bne;
          rv_isa_pkg::f3_blt:  ctrl.alu_op = rv_core_pkg::alu_blt;
          rv_isa_pkg::f3_bge:  ctrl.alu_op = rv_core_pkg::alu_bge;
          rv_isa_pkg::f3_bltu: ctrl.alu_op = rv_core_pkg::alu_bltu;
          rv_isa_pkg::f3_bgeu: ctrl.alu_op = rv_core_pkg::alu_bgeu;
          default:             ctrl.illegal = 1'b1;
        endcase
      end
      rv_isa_pkg::op_load: begin
        ctrl.is_load  = 1'b1;
        ctrl.need_imm = 1'b1;
        ctrl.reg_wen  = 1'b1;
        imm           = imm_i;
        case (funct3)
          rv_isa_pkg::f3_byte: ctrl.mem_width = rv_core_pkg::mw_byte;
          rv_isa_pkg::f3_half: ctrl.mem_width = rv_core_pkg::mw_half;
          rv_isa_pkg::f3_word: ctrl.mem_width = rv_core_pkg::mw_word;
          rv_isa_pkg::f3_byte_u: begin
            ctrl.mem_width   = rv_core_pkg::mw_byte;
            ctrl.is_unsigned = 1'b1;
          end
          rv_isa_pkg::f3_half_u: begin
            ctrl.mem_width   = rv_core_pkg::mw_half;
            ctrl.is_unsigned = 1'b1;
          end
          default: ctrl.illegal = 1'b1;
        endcase
      end
      rv_isa_pkg::op_store: begin
        ctrl.mem_wen  = 1'b1;
        ctrl.need_imm = 1'b1;
        imm           = imm_s;
        case (funct3)
          rv_isa_pkg::f3_byte: ctrl.mem_width = rv_core_pkg::mw_byte;
          rv_isa_pkg::f3_half: ctrl.mem_width = rv_core_pkg::mw_half;
          rv_isa_pkg::f3_word: ctrl.mem_width = rv_core_pkg::mw_word;
          default:             ctrl.illegal = 1'b1;
        endcase
      end
      rv_isa_pkg::op_imm: begin
        // funct7 only matters for the shift forms
        ctrl.need_imm = 1'b1;
        ctrl.reg_wen  = 1'b1;
        ctrl.alu_op   = arith_op(funct3, is_shift && funct7[5]);
        ctrl.illegal  = is_shift && (funct7 != rv_isa_pkg::f7_base) &&
                        !((funct7 == rv_isa_pkg::f7_alt) && (funct3 == rv_isa_pkg::f3_srl_sra));
        imm           = imm_i;
      end
      rv_isa_pkg::op_op: begin
        ctrl.reg_wen = 1'b1;
        ctrl.alu_op  = arith_op(funct3, funct7[5]);
        ctrl.illegal = (funct7 != rv_isa_pkg::f7_base) &&
                       !((funct7 == rv_isa_pkg::f7_alt) &&
                         ((funct3 == rv_isa_pkg::f3_add_sub) ||
                          (funct3 == rv_isa_pkg::f3_srl_sra)));
      end
      rv_isa_pkg::op_system: begin
        // only ebreak, ecall and csr access are not supported
        ctrl.is_ebreak = (inst == rv_isa_pkg::ebreak_inst);
        ctrl.illegal   = (inst != rv_isa_pkg::ebreak_inst);
      end
      default: ctrl.illegal = 1'b1;
    endcase
    if (ctrl.illegal) begin
      ctrl.reg_wen = 1'b0;
      ctrl.mem_wen = 1'b0;
    end
  end

endmodule

/* rv_alu.sv */
// integer ALU with branch compare
`timescale 1ns/10ps

module rv_alu (
  input  logic [rv_isa_pkg::xlen-1:0] operand_a,
  input  logic [rv_isa_pkg::xlen-1:0] operand_b,
  input  rv_core_pkg::alu_op_e        alu_op,
  output logic [rv_isa_pkg::xlen-1:0] result,
  output logic                        taken
);

  logic [rv_isa_pkg::shamt_w-1:0] shamt;
  logic                           lt_s;
  logic                           lt_u;

  assign shamt = operand_b[rv_isa_pkg::shamt_w-1:0];
  assign lt_s  = $signed(operand_a) < $signed(operand_b);
  assign lt_u  = operand_a < operand_b;

  always_comb begin
    result = '0;
    taken  = 1'b0;
    case (alu_op)
      rv_core_pkg::alu_add:    result = operand_a + operand_b;
      rv_core_pkg::alu_sub:    result = operand_a - operand_b;
      rv_core_pkg::alu_sll:    result = operand_a << shamt;
      rv_core_pkg::alu_slt:    result = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_s};
      rv_core_pkg::alu_sltu:   result = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_u};
      rv_core_pkg::alu_xor:    result = operand_a ^ operand_b;
      rv_core_pkg::alu_srl:    result = operand_a >> shamt;
      rv_core_pkg::alu_sra:    result = $unsigned($signed(operand_a) >>> shamt);
      rv_core_pkg::alu_or:     result = operand_a | operand_b;
      rv_core_pkg::alu_and:    result = operand_a & operand_b;
      // branch conditions only drive taken
      rv_core_pkg::alu_beq:    taken = (operand_a == operand_b);
      rv_core_pkg::alu_bne:    taken = (operand_a != operand_b);
      rv_core_pkg::alu_blt:    taken = lt_s;
      rv_core_pkg::alu_bge:    taken = !lt_s;
      rv_core_pkg::alu_bltu:   taken = lt_u;
      rv_core_pkg::alu_bgeu:   taken = !lt_u;
      rv_core_pkg::alu_pass_b: result = operand_b;
      default:                 result = '0;
    endcase
  end

endmodule

/* rv_regfile.sv */
// integer register file
`timescale 1ns/10ps

module rv_regfile (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [rv_isa_pkg::reg_idx_w-1:0] rs1,
  input  logic [rv_isa_pkg::reg_idx_w-1:0] rs2,
  input  logic [rv_isa_pkg::reg_idx_w-1:0] rd,
  input  logic                           wen,
  input  logic [rv_isa_pkg::xlen-1:0]    wdata,
  output logic [rv_isa_pkg::xlen-1:0]    rdata_1,
  output logic [rv_isa_pkg::xlen-1:0]    rdata_2
);

  logic [rv_isa_pkg::xlen-1:0] regs [rv_isa_pkg::num_regs];

  // x0 stays at its reset value since it is never written
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < rv_isa_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata_1 = regs[rs1];
  assign rdata_2 = regs[rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (rs1 == '0) |-> (rdata_1 == '0));

endmodule

/* rv_data_mem.sv */
// data RAM with byte lanes
`timescale 1ns/10ps

module rv_data_mem (
  input  logic                        clk,
  input  rv_core_pkg::store_t         store,
  input  logic [rv_isa_pkg::xlen-1:0] raddr,
  input  rv_core_pkg::mem_width_e     rwidth,
  input  logic                        is_unsigned,
  output logic [rv_isa_pkg::xlen-1:0] rdata
);

  logic [rv_isa_pkg::xlen-1:0]   mem [rv_core_pkg::dmem_words];
  logic [rv_core_pkg::dmem_idx_w-1:0] widx;
  logic [rv_core_pkg::dmem_idx_w-1:0] ridx;
  logic [3:0]                    byte_en;
  logic [rv_isa_pkg::xlen-1:0]   wlanes;
  logic [rv_isa_pkg::xlen-1:0]   rword;
  logic [rv_isa_pkg::xlen-1:0]   rshift;

  assign widx = store.addr[rv_core_pkg::dmem_idx_w+1:2];
  assign ridx = raddr[rv_core_pkg::dmem_idx_w+1:2];

  // replicate store data over every lane, the mask picks the live ones
  always_comb begin
    case (store.width)
      rv_core_pkg::mw_byte: begin
        byte_en = 4'b0001 << store.addr[1:0];
        wlanes  = {4{store.data[7:0]}};
      end
      rv_core_pkg::mw_half: begin
        byte_en = 4'b0011 << store.addr[1:0];
        wlanes  = {2{store.data[15:0]}};
      end
      default: begin
        byte_en = 4'b1111;
        wlanes  = store.data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (store.valid) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_en[i]) begin
          mem[widx][8*i +: 8] <= wlanes[8*i +: 8];
        end
      end
    end
  end

  // load path, addressed lane shifted down then extended
  assign rword  = mem[ridx];
  assign rshift = rword >> {raddr[1:0], 3'b000};

  always_comb begin
    case (rwidth)
      rv_core_pkg::mw_byte:
        rdata = is_unsigned ? {24'b0, rshift[7:0]} : {{24{rshift[7]}}, rshift[7:0]};
      rv_core_pkg::mw_half:
        rdata = is_unsigned ? {16'b0, rshift[15:0]} : {{16{rshift[15]}}, rshift[15:0]};
      default:
        rdata = rword;
    endcase
  end

  a_store_aligned: assert property (@(posedge clk)
    store.valid |->
      !((store.width == rv_core_pkg::mw_half) && store.addr[0]) &&
      !((store.width == rv_core_pkg::mw_word) && (store.addr[1:0] != 2'b00)));

endmodule

/* rv_core.sv */
// two-stage RV32I core
`timescale 1ns/10ps

module rv_core (
  input  logic                        clk,
  input  logic                        rst_n,
  output logic [rv_isa_pkg::xlen-1:0] imem_addr,
  input  logic [rv_isa_pkg::xlen-1:0] imem_inst,
  output rv_core_pkg::store_t         store,
  output logic                        halted,
  output logic                        trap
);

  typedef struct packed {
    logic [rv_isa_pkg::xlen-1:0] pc;
    logic [rv_isa_pkg::xlen-1:0] inst;
  } if_id_t;

  logic [rv_isa_pkg::xlen-1:0]      pc;
  logic [rv_isa_pkg::xlen-1:0]      next_pc;
  if_id_t                           if_id;
  logic [rv_isa_pkg::reg_idx_w-1:0] rd;
  logic [rv_isa_pkg::reg_idx_w-1:0] rs1;
  logic [rv_isa_pkg::reg_idx_w-1:0] rs2;
  logic [rv_isa_pkg::xlen-1:0]      imm;
  rv_core_pkg::ctrl_t               ctrl;
  logic [rv_isa_pkg::xlen-1:0]      rdata_1;
  logic [rv_isa_pkg::xlen-1:0]      rdata_2;
  logic [rv_isa_pkg::xlen-1:0]      operand_a;
  logic [rv_isa_pkg::xlen-1:0]      operand_b;
  logic [rv_isa_pkg::xlen-1:0]      alu_result;
  logic                             taken;
  logic [rv_isa_pkg::xlen-1:0]      load_data;
  logic [rv_isa_pkg::xlen-1:0]      wb_data;
  logic                             link;
  logic                             flush;
  logic                             frozen;
  logic                             stop;

  assign frozen = halted | trap;
  // hold fetch from the cycle the halting instruction executes
  assign stop   = frozen | ctrl.is_ebreak | ctrl.illegal;
  assign link   = ctrl.is_jal | ctrl.is_jalr;
  assign flush  = link | (ctrl.is_branch & taken);

  // fetch
  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= rv_core_pkg::reset_pc;
    end else if (!stop) begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      if_id.pc   <= rv_core_pkg::reset_pc;
      if_id.inst <= rv_isa_pkg::nop_inst;
    end else if (!stop) begin
      if_id.pc   <= pc;
      if_id.inst <= flush ? rv_isa_pkg::nop_inst : imem_inst;
    end
  end

  // execute
  rv_decoder decoder_i (
    .inst (if_id.inst),
    .rd   (rd),
    .rs1  (rs1),
    .rs2  (rs2),
    .imm  (imm),
    .ctrl (ctrl)
  );

  rv_regfile regfile_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .wen     (ctrl.reg_wen & ~frozen),
    .wdata   (wb_data),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  assign operand_a = ctrl.pc_operand ? if_id.pc : rdata_1;
  assign operand_b = ctrl.need_imm ? imm : rdata_2;

  rv_alu alu_i (
    .operand_a (operand_a),
    .operand_b (operand_b),
    .alu_op    (ctrl.alu_op),
    .result    (alu_result),
    .taken     (taken)
  );

  assign store.valid = ctrl.mem_wen & ~frozen;
  assign store.addr  = alu_result;
  assign store.data  = rdata_2;
  assign store.width = ctrl.mem_width;

  rv_data_mem data_mem_i (
    .clk         (clk),
    .store       (store),
    .raddr       (alu_result),
    .rwidth      (ctrl.mem_width),
    .is_unsigned (ctrl.is_unsigned),
    .rdata       (load_data)
  );

  always_comb begin
    if (link) begin
      wb_data = if_id.pc + 32'd4;
    end else if (ctrl.is_load) begin
      wb_data = load_data;
    end else begin
      wb_data = alu_result;
    end
  end

  // jump targets have bit 0 cleared, jal targets are already even
  always_comb begin
    if (link) begin
      next_pc = alu_result & ~32'd1;
    end else if (ctrl.is_branch && taken) begin
      next_pc = if_id.pc + imm;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  // sticky status until reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
      trap   <= 1'b0;
    end else if (!frozen) begin
      halted <= ctrl.is_ebreak;
      trap   <= ctrl.illegal;
    end
  end

  a_no_store_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    frozen |-> !ctrl.mem_wen);

  a_halt_trap_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(halted && trap));

endmodule

/* tb_rv_core.sv */
// testbench for the two-stage core
`timescale 1ns/10ps

module tb_rv_core;

  localparam int num_tests   = 10;
  localparam int max_prog    = 16;
  localparam int max_stores  = 8;
  localparam int max_cycles  = 64;
  localparam int settle      = 3;
  localparam int watchdog_ns = num_tests * 70 * 4;

  logic                        clk;
  logic                        rst_n;
  logic [rv_isa_pkg::xlen-1:0] imem_addr;
  logic [rv_isa_pkg::xlen-1:0] imem_inst;
  rv_core_pkg::store_t         store;
  logic                        halted;
  logic                        trap;

  // program table with one row per test
  logic [31:0]             prog      [num_tests][max_prog];
  int                      prog_len  [num_tests];
  logic [31:0]             exp_addr  [num_tests][max_stores];
  logic [31:0]             exp_data  [num_tests][max_stores];
  rv_core_pkg::mem_width_e exp_width [num_tests][max_stores];
  int                      exp_cnt   [num_tests];
  logic                    exp_trap  [num_tests];

  int          n_tests;
  int          cur;
  int          test_errs;
  int          n_pass;
  int          n_fail;
  logic [15:0] lfsr = 16'd61;

  rv_core dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_inst (imem_inst),
    .store     (store),
    .halted    (halted),
    .trap      (trap)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // same-cycle instruction memory, nop past the program or off a word boundary
  always_comb begin
    if ((imem_addr[1:0] == 2'b00) && ({2'b00, imem_addr[31:2]} < prog_len[cur])) begin
      imem_inst = prog[cur][imem_addr[5:2]];
    end else begin
      imem_inst = rv_isa_pkg::nop_inst;
    end
  end

  // instruction formats
  function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_isa_pkg::op_op};
  endfunction

  function automatic logic [31:0] i_type(input rv_isa_pkg::opcode_e op, input int imm,
                                          input int rs1, input logic [2:0] f3, input int rd);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], rv_isa_pkg::op_store};
  endfunction

  function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
            rv_isa_pkg::op_branch};
  endfunction

  function automatic logic [31:0] u_type(input rv_isa_pkg::opcode_e op, input int imm,
                                          input int rd);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_isa_pkg::op_jal};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return i_type(rv_isa_pkg::op_imm, imm, rs1, rv_isa_pkg::f3_add_sub, rd);
  endfunction

  // word store with x0 as base
  function automatic logic [31:0] store_word(input int rs2, input int offset);
    return s_type(offset, rs2, 0, rv_isa_pkg::f3_word);
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // fibonacci lfsr with taps 16 14 13 11 stepped once per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
  endtask

  task automatic add_inst(input logic [31:0] w);
    prog[n_tests][prog_len[n_tests]] = w;
    prog_len[n_tests]++;
  endtask

  task automatic add_store(input int addr, input logic [31:0] data,
                           input rv_core_pkg::mem_width_e w);
    exp_addr[n_tests][exp_cnt[n_tests]]  = addr;
    exp_data[n_tests][exp_cnt[n_tests]]  = data;
    exp_width[n_tests][exp_cnt[n_tests]] = w;
    exp_cnt[n_tests]++;
  endtask

  task automatic close_test(input logic ends_in_trap);
    add_inst(rv_isa_pkg::ebreak_inst);
    exp_trap[n_tests] = ends_in_trap;
    n_tests++;
  endtask

  task automatic build_tests();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] x1;
    logic [31:0] x2;
    logic [31:0] x3;
    // random immediates through addi and xori
    take_bits(12, r1);
    take_bits(12, r2);
    take_bits(12, r3);
    x1 = sext12(r1[11:0]);
    x2 = x1 ^ sext12(r2[11:0]);
    x3 = x2 + sext12(r3[11:0]);
    add_inst(addi(1, 0, r1));
    add_inst(i_type(rv_isa_pkg::op_imm, r2, 1, rv_isa_pkg::f3_xor, 2));
    add_inst(addi(3, 2, r3));
    for (int i = 1; i <= 3; i++) add_inst(store_word(i, 4 * (i - 1)));
    add_store(0, x1, rv_core_pkg::mw_word);
    add_store(4, x2, rv_core_pkg::mw_word);
    add_store(8, x3, rv_core_pkg::mw_word);
    close_test(1'b0);
    // register-register ops on -5 and 3
    add_inst(addi(1, 0, 'hFFB));
    add_inst(addi(2, 0, 3));
    add_inst(r_type(rv_isa_pkg::f7_base, 2, 1, rv_isa_pkg::f3_add_sub, 3));
    add_inst(r_type(rv_isa_pkg::f7_alt, 1, 2, rv_isa_pkg::f3_add_sub, 4));
    add_inst(r_type(rv_isa_pkg::f7_base, 2, 1, rv_isa_pkg::f3_slt, 5));
    add_inst(r_type(rv_isa_pkg::f7_base, 2, 1, rv_isa_pkg::f3_sltu, 6));
    add_inst(r_type(rv_isa_pkg::f7_base, 2, 1, rv_isa_pkg::f3_and, 7));
    add_inst(r_type(rv_isa_pkg::f7_base, 2, 1, rv_isa_pkg::f3_or, 8));
    for (int i = 3; i <= 8; i++) add_inst(store_word(i, 4 * (i - 3)));
    add_store(0, 32'hFFFF_FFFE, rv_core_pkg::mw_word);
    add_store(4, 32'd8, rv_core_pkg::mw_word);
    add_store(8, 32'd1, rv_core_pkg::mw_word);
    add_store(12, 32'd0, rv_core_pkg::mw_word);
    add_store(16, 32'd3, rv_core_pkg::mw_word);
    add_store(20, 32'hFFFF_FFFB, rv_core_pkg::mw_word);
    close_test(1'b0);
    // immediate shifts, lui, auipc at pc 0x14 and a write to x0
    add_inst(addi(1, 0, 'hFFB));
    add_inst(i_type(rv_isa_pkg::op_imm, 'h004, 1, rv_isa_pkg::f3_sll, 2));
    add_inst(i_type(rv_isa_pkg::op_imm, 'h01C, 1, rv_isa_pkg::f3_srl_sra, 3));
    add_inst(i_type(rv_isa_pkg::op_imm, 'h401, 1, rv_isa_pkg::f3_srl_sra, 4));
    add_inst(u_type(rv_isa_pkg::op_lui, 'h12345, 5));
    add_inst(u_type(rv_isa_pkg::op_auipc, 'h00001, 6));
    add_inst(addi(0, 1, 7));
    for (int i = 2; i <= 6; i++) add_inst(store_word(i, 4 * (i - 2)));
    add_inst(store_word(0, 20));
    add_store(0, 32'hFFFF_FFB0, rv_core_pkg::mw_word);
    add_store(4, 32'h0000_000F, rv_core_pkg::mw_word);
    add_store(8, 32'hFFFF_FFFD, rv_core_pkg::mw_word);
    add_store(12, 32'h1234_5000, rv_core_pkg::mw_word);
    add_store(16, 32'h0000_1014, rv_core_pkg::mw_word);
    add_store(20, 32'h0000_0000, rv_core_pkg::mw_word);
    close_test(1'b0);
    // every branch taken and each skipping a store to 0x40
    add_inst(addi(1, 0, 1));
    add_inst(addi(2, 0, 2));
    add_inst(b_type(8, 1, 1, rv_isa_pkg::f3_beq));
    add_inst(store_word(1, 'h40));
    add_inst(b_type(8, 2, 1, rv_isa_pkg::f3_bne));
    add_inst(store_word(1, 'h40));
    add_inst(b_type(8, 2, 1, rv_isa_pkg::f3_blt));
    add_inst(store_word(1, 'h40));
    add_inst(b_type(8, 1, 2, rv_isa_pkg::f3_bge));
    add_inst(store_word(1, 'h40));
    add_inst(b_type(8, 2, 1, rv_isa_pkg::f3_bltu));
    add_inst(store_word(1, 'h40));
    add_inst(b_type(8, 1, 2, rv_isa_pkg::f3_bgeu));
    add_inst(store_word(1, 'h40));
    add_inst(store_word(2, 0));
    add_store(0, 32'd2, rv_core_pkg::mw_word);
    close_test(1'b0);
    // every branch falls through
    add_inst(addi(1, 0, 1));
    add_inst(addi(2, 0, 2));
    add_inst(b_type(8, 2, 1, rv_isa_pkg::f3_beq));
    add_inst(store_word(1, 0));
    add_inst(b_type(8, 1, 1, rv_isa_pkg::f3_bne));
    add_inst(store_word(1, 4));
    add_inst(b_type(8, 1, 2, rv_isa_pkg::f3_blt));
    add_inst(store_word(1, 8));
    add_inst(b_type(8, 2, 1, rv_isa_pkg::f3_bge));
    add_inst(store_word(1, 12));
    add_inst(b_type(8, 1, 2, rv_isa_pkg::f3_bltu));
    add_inst(store_word(1, 16));
    add_inst(b_type(8, 2, 1, rv_isa_pkg::f3_bgeu));
    add_inst(store_word(1, 20));
    for (int i = 0; i < 6; i++) add_store(4 * i, 32'd1, rv_core_pkg::mw_word);
    close_test(1'b0);
    // jal to 8 then jalr to 25 landing on 24
    add_inst(j_type(8, 1));
    add_inst(store_word(0, 'h40));
    add_inst(store_word(1, 0));
    add_inst(addi(2, 0, 25));
    add_inst(i_type(rv_isa_pkg::op_jalr, 0, 2, rv_isa_pkg::f3_jalr, 3));
    add_inst(store_word(0, 'h44));
    add_inst(store_word(3, 4));
    add_store(0, 32'd4, rv_core_pkg::mw_word);
    add_store(4, 32'd20, rv_core_pkg::mw_word);
    close_test(1'b0);
    // loads of every width from 0x89abcdef at 0x20
    add_inst(u_type(rv_isa_pkg::op_lui, 'h89ABD, 1));
    add_inst(addi(1, 1, 'hDEF));
    add_inst(store_word(1, 'h20));
    add_inst(i_type(rv_isa_pkg::op_load, 'h20, 0, rv_isa_pkg::f3_byte, 2));
    add_inst(i_type(rv_isa_pkg::op_load, 'h23, 0, rv_isa_pkg::f3_byte_u, 3));
    add_inst(i_type(rv_isa_pkg::op_load, 'h22, 0, rv_isa_pkg::f3_half, 4));
    add_inst(i_type(rv_isa_pkg::op_load, 'h20, 0, rv_isa_pkg::f3_half_u, 5));
    add_inst(i_type(rv_isa_pkg::op_load, 'h20, 0, rv_isa_pkg::f3_word, 6));
    for (int i = 2; i <= 6; i++) add_inst(store_word(i, 4 * (i - 2)));
    add_store('h20, 32'h89AB_CDEF, rv_core_pkg::mw_word);
    add_store(0, 32'hFFFF_FFEF, rv_core_pkg::mw_word);
    add_store(4, 32'h0000_0089, rv_core_pkg::mw_word);
    add_store(8, 32'hFFFF_89AB, rv_core_pkg::mw_word);
    add_store(12, 32'h0000_CDEF, rv_core_pkg::mw_word);
    add_store(16, 32'h89AB_CDEF, rv_core_pkg::mw_word);
    close_test(1'b0);
    // byte and half stores merged into a cleared word
    add_inst(u_type(rv_isa_pkg::op_lui, 'h89ABD, 1));
    add_inst(addi(1, 1, 'hDEF));
    add_inst(store_word(0, 'h30));
    add_inst(s_type('h31, 1, 0, rv_isa_pkg::f3_byte));
    add_inst(s_type('h32, 1, 0, rv_isa_pkg::f3_half));
    add_inst(i_type(rv_isa_pkg::op_load, 'h30, 0, rv_isa_pkg::f3_word, 2));
    add_inst(i_type(rv_isa_pkg::op_load, 'h31, 0, rv_isa_pkg::f3_byte_u, 3));
    add_inst(i_type(rv_isa_pkg::op_load, 'h32, 0, rv_isa_pkg::f3_half, 4));
    for (int i = 2; i <= 4; i++) add_inst(store_word(i, 4 * (i - 2)));
    add_store('h30, 32'h0000_0000, rv_core_pkg::mw_word);
    add_store('h31, 32'h89AB_CDEF, rv_core_pkg::mw_byte);
    add_store('h32, 32'h89AB_CDEF, rv_core_pkg::mw_half);
    add_store(0, 32'hCDEF_EF00, rv_core_pkg::mw_word);
    add_store(4, 32'h0000_00EF, rv_core_pkg::mw_word);
    add_store(8, 32'hFFFF_CDEF, rv_core_pkg::mw_word);
    close_test(1'b0);
    // nothing after ebreak may store
    add_inst(addi(1, 0, 5));
    add_inst(store_word(1, 0));
    add_inst(rv_isa_pkg::ebreak_inst);
    add_inst(store_word(1, 4));
    add_store(0, 32'd5, rv_core_pkg::mw_word);
    close_test(1'b0);
    // custom-0 opcode with rd x1 must trap
    add_inst(addi(1, 0, 9));
    add_inst(store_word(1, 0));
    add_inst(32'h0000_008B);
    add_inst(store_word(1, 4));
    add_store(0, 32'd9, rv_core_pkg::mw_word);
    close_test(1'b1);
  endtask

  task automatic report_value(input int t, input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    $display("ERR %0t: test %0d %s expected %h actual %h", $time, t, what, exp, act);
    test_errs++;
  endtask

  task automatic run_test(input int t);
    rv_core_pkg::store_t got[$];
    int                  cycles;
    logic [31:0]         hold_addr;
    test_errs = 0;
    cycles    = 0;
    @(negedge clk);
    rst_n = 1'b0;
    cur   = t;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    while (!(halted || trap) && cycles < max_cycles) begin
      @(negedge clk);
      if (store.valid) got.push_back(store);
      cycles++;
    end
    if (!(halted || trap)) begin
      $display("test %0d: core neither halted nor trapped within %0d cycles", t, max_cycles);
      test_errs++;
    end else begin
      // frozen core keeps its fetch address and stays silent
      hold_addr = imem_addr;
      repeat (settle) begin
        @(negedge clk);
        if (store.valid) got.push_back(store);
        if (imem_addr !== hold_addr) report_value(t, "frozen imem_addr", hold_addr, imem_addr);
      end
      if (exp_trap[t] && !trap) begin
        $display("test %0d: core halted where a trap was expected", t);
        test_errs++;
      end
      if (!exp_trap[t] && !halted) begin
        $display("test %0d: core trapped where a halt was expected", t);
        test_errs++;
      end
    end
    if (got.size() != exp_cnt[t]) report_value(t, "store count", exp_cnt[t], got.size());
    for (int i = 0; i < got.size() && i < exp_cnt[t]; i++) begin
      if (got[i].addr !== exp_addr[t][i]) begin
        report_value(t, $sformatf("store %0d addr", i), exp_addr[t][i], got[i].addr);
      end
      if (got[i].data !== exp_data[t][i]) begin
        report_value(t, $sformatf("store %0d data", i), exp_data[t][i], got[i].data);
      end
      if (got[i].width !== exp_width[t][i]) begin
        report_value(t, $sformatf("store %0d width", i), {30'b0, exp_width[t][i]},
                     {30'b0, got[i].width});
      end
    end
    if (test_errs == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("test %0d done: %0d stores, %0d errors", t, got.size(), test_errs);
  endtask

  initial begin
    rst_n = 1'b0;
    build_tests();
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired at %0t before all tests finished", $time);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* sources.f */
rv_isa_pkg.sv
rv_core_pkg.sv
rv_decoder.sv
rv_alu.sv
rv_regfile.sv
rv_data_mem.sv
rv_core.sv
tb_rv_core.sv

/* Makefile */
TOP = tb_rv_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -f sources.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
